/* hw/free_list.sv */
/*
  speculative free set of physical registers
  alloc_phys offers the highest free index and is 0 when the set is empty
  p0 is never offered
  restore reloads the set and has priority over take and release
*/
`timescale 1ns/1ns

module free_list
  import id_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 take,
  input  phys_idx_t            release_phys,
  input  logic                 restore,
  input  logic [phys_regs-1:0] restore_set,
  output phys_idx_t            alloc_phys,
  output logic                 empty
);

  logic [phys_regs-1:0] free_set;

  //////////////////////////////////////////////////
  // selection
  //////////////////////////////////////////////////

  // upward scan so the last hit is the highest index
  always_comb
  begin
    alloc_phys = '0;
    for (int i = 1; i < phys_regs; i++)
    begin
      if (free_set[i])
        alloc_phys = phys_idx_t'(i);
    end
  end

  assign empty = (free_set[phys_regs-1:1] == '0);

  //////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      free_set <= init_free;
    else if (restore)
      free_set <= restore_set;
    else
    begin
      if (take)
        free_set[alloc_phys] <= 1'b0;
      if (release_phys != '0)
        free_set[release_phys] <= 1'b1; // returned by a commit
    end
  end

endmodule

/* hw/id_pkg.sv */
/*
  shared sizes, types and encodings for the decode and rename stage
  physical register 0 is reserved and always reads as ready
  architectural register 31 is the zero register and is never renamed
  only integer groups decode, so floating point opcodes come out illegal
*/
package id_pkg;

  localparam int arch_regs  = 32;
  localparam int arch_width = 5;
  localparam int phys_regs  = 64;
  localparam int phys_width = 6;

  typedef logic [arch_width-1:0] arch_idx_t;
  typedef logic [phys_width-1:0] phys_idx_t;

  localparam arch_idx_t zero_reg = 5'd31;
  localparam logic [phys_regs-1:0] init_free = {{(phys_regs-1){1'b1}}, 1'b0}; // all but p0
  localparam logic [25:0] pal_halt = 26'h555;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  typedef enum logic [5:0] {
    op_pal  = 6'h00,
    op_lda  = 6'h08,
    op_inta = 6'h10, // add, sub, compares
    op_intl = 6'h11, // logic
    op_ints = 6'h12, // shifts
    op_intm = 6'h13, // multiply
    op_jsr  = 6'h1a, // jmp, jsr, ret, jsr_co
    op_ldq  = 6'h29,
    op_stq  = 6'h2d,
    op_br   = 6'h30,
    op_bsr  = 6'h34
  } opcode_e;

  // function field, inst[11:5]
  localparam logic [6:0] fn_addq   = 7'h20;
  localparam logic [6:0] fn_subq   = 7'h29;
  localparam logic [6:0] fn_cmpeq  = 7'h2d;
  localparam logic [6:0] fn_cmpult = 7'h1d;
  localparam logic [6:0] fn_cmpule = 7'h3d;
  localparam logic [6:0] fn_cmplt  = 7'h4d;
  localparam logic [6:0] fn_cmple  = 7'h6d;
  localparam logic [6:0] fn_and    = 7'h00;
  localparam logic [6:0] fn_bic    = 7'h08;
  localparam logic [6:0] fn_bis    = 7'h20;
  localparam logic [6:0] fn_ornot  = 7'h28;
  localparam logic [6:0] fn_xor    = 7'h40;
  localparam logic [6:0] fn_eqv    = 7'h48;
  localparam logic [6:0] fn_srl    = 7'h34;
  localparam logic [6:0] fn_sll    = 7'h39;
  localparam logic [6:0] fn_sra    = 7'h3c;
  localparam logic [6:0] fn_mulq   = 7'h20;

  typedef enum logic [4:0] {
    alu_addq, alu_subq, alu_and, alu_bic, alu_bis, alu_ornot,
    alu_xor, alu_eqv, alu_srl, alu_sll, alu_sra, alu_mulq,
    alu_cmpeq, alu_cmplt, alu_cmple, alu_cmpult, alu_cmpule
  } alu_func_e;

  typedef enum logic [1:0] {opa_rega, opa_mem_disp, opa_npc, opa_not3} opa_sel_e;
  typedef enum logic [1:0] {opb_regb, opb_imm, opb_br_disp} opb_sel_e;
  typedef enum logic [1:0] {dest_rega, dest_regc, dest_none} dest_sel_e;

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    alu_func_e alu_func;
    logic      rd_mem;
    logic      wr_mem;
    logic      cond_branch;
    logic      uncond_branch;
    logic      halt;
    logic      illegal;
    logic      valid;   // renames and issues
  } decode_t;

  typedef struct packed {
    logic      valid;
    arch_idx_t arch;
    phys_idx_t phys;
  } commit_t;

endpackage

/* hw/id_stage.sv */
/*
  decode and rename stage, single cycle
  decode, source lookup, readiness, dest_phys and stall are combinational
  allocation, commits and mispredict recovery take effect at the next edge
  upstream holds the instruction while stall is high
*/
`timescale 1ns/1ns

module id_stage
  import id_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst,
  input  logic        inst_valid,
  input  commit_t     commit,
  input  logic        mispredict,
  input  phys_idx_t   cdb_tag,    // 0 when idle
  output decode_t     dec,
  output phys_idx_t   src_a_phys,
  output phys_idx_t   src_b_phys,
  output logic        src_a_ready,
  output logic        src_b_ready,
  output arch_idx_t   dest_arch,
  output phys_idx_t   dest_phys,
  output logic        stall
);

  arch_idx_t                 src_a;
  arch_idx_t                 src_b;
  logic                      needs_dest;
  logic                      rename_en;
  phys_idx_t                 alloc_phys;
  logic                      empty;
  phys_idx_t [arch_regs-1:0] committed_map;
  logic [phys_regs-1:0]      committed_free;
  phys_idx_t                 freed_phys;
  logic [phys_regs-1:0]      clear_set;
  logic                      ready_a;
  logic                      ready_b;

  assign src_a = inst[25:21];
  assign src_b = inst[20:16];

  //////////////////////////////////////////////////
  // rename control
  //////////////////////////////////////////////////

  assign needs_dest = dec.valid && (dest_arch != zero_reg);
  assign stall      = needs_dest && empty;
  assign rename_en  = needs_dest && !stall && !mispredict;
  assign dest_phys  = rename_en ? alloc_phys : '0;

  // freed by a commit, or everything free after recovery
  assign clear_set = mispredict ? committed_free :
                     (freed_phys != '0) ? (phys_regs'(1) << freed_phys) : '0;

  assign src_a_ready = (src_a == zero_reg) || ready_a;
  assign src_b_ready = (src_b == zero_reg) || ready_b;

  inst_decoder u_dec (.inst(inst), .inst_valid(inst_valid), .dec(dec), .dest_arch(dest_arch));

  map_table u_map (
    .clock(clock), .reset(reset), .src_a(src_a), .src_b(src_b),
    .rename_en(rename_en), .dest_arch(dest_arch), .dest_phys(dest_phys),
    .restore(mispredict), .restore_map(committed_map),
    .src_a_phys(src_a_phys), .src_b_phys(src_b_phys)
  );

  free_list u_free (
    .clock(clock), .reset(reset), .take(rename_en), .release_phys(freed_phys),
    .restore(mispredict), .restore_set(committed_free),
    .alloc_phys(alloc_phys), .empty(empty)
  );

  retire_map u_retire (
    .clock(clock), .reset(reset), .commit(commit), .committed_map(committed_map),
    .committed_free(committed_free), .freed_phys(freed_phys)
  );

  ready_list u_ready (
    .clock(clock), .reset(reset), .cdb_tag(cdb_tag), .clear_set(clear_set),
    .clear_phys(dest_phys), // new destination starts not ready
    .look_a(src_a_phys), .look_b(src_b_phys), .ready_a(ready_a), .ready_b(ready_b)
  );

endmodule

/* hw/inst_decoder.sv */
/*
  combinational decoder for the integer subset
  outputs stay at a noop when inst_valid is low
  halt and illegal instructions come out with valid low and no destination
*/
`timescale 1ns/1ns

module inst_decoder
  import id_pkg::*;
(
  input  logic [31:0] inst,
  input  logic        inst_valid,
  output decode_t     dec,
  output arch_idx_t   dest_arch
);

  dest_sel_e  dest_sel;
  logic [6:0] func;

  assign func = inst[11:5];

  always_comb
  begin
    dec = '0; // noop
    dest_sel = dest_none;
    if (inst_valid)
    begin
      case (inst[31:26])
        op_pal:
          if (inst[25:0] == pal_halt)
            dec.halt = 1'b1;
          else
            dec.illegal = 1'b1;
        op_inta, op_intl, op_ints, op_intm:
        begin
          dec.opa_sel = opa_rega;
          if (inst[12])
            dec.opb_sel = opb_imm; // 8-bit literal form
          else
            dec.opb_sel = opb_regb;
          dest_sel = dest_regc;
          case ({inst[31:26], func})
            {op_inta, fn_addq}:   dec.alu_func = alu_addq;
            {op_inta, fn_subq}:   dec.alu_func = alu_subq;
            {op_inta, fn_cmpeq}:  dec.alu_func = alu_cmpeq;
            {op_inta, fn_cmpult}: dec.alu_func = alu_cmpult;
            {op_inta, fn_cmpule}: dec.alu_func = alu_cmpule;
            {op_inta, fn_cmplt}:  dec.alu_func = alu_cmplt;
            {op_inta, fn_cmple}:  dec.alu_func = alu_cmple;
            {op_intl, fn_and}:    dec.alu_func = alu_and;
            {op_intl, fn_bic}:    dec.alu_func = alu_bic;
            {op_intl, fn_bis}:    dec.alu_func = alu_bis;
            {op_intl, fn_ornot}:  dec.alu_func = alu_ornot;
            {op_intl, fn_xor}:    dec.alu_func = alu_xor;
            {op_intl, fn_eqv}:    dec.alu_func = alu_eqv;
            {op_ints, fn_srl}:    dec.alu_func = alu_srl;
            {op_ints, fn_sll}:    dec.alu_func = alu_sll;
            {op_ints, fn_sra}:    dec.alu_func = alu_sra;
            {op_intm, fn_mulq}:   dec.alu_func = alu_mulq;
            default:              dec.illegal = 1'b1;
          endcase
        end
        op_jsr:
        begin
          dec.opa_sel = opa_not3;
          dec.opb_sel = opb_regb;
          dec.alu_func = alu_and; // word-align the target
          dest_sel = dest_rega;
          dec.uncond_branch = 1'b1;
        end
        op_lda, op_ldq, op_stq:
        begin
          dec.opa_sel = opa_mem_disp;
          dec.opb_sel = opb_regb;
          dec.alu_func = alu_addq; // base plus displacement
          dest_sel = dest_rega;
          if (inst[31:26] == op_stq)
          begin
            dec.wr_mem = 1'b1;
            dest_sel = dest_none; // ra is data, not a target
          end
          else if (inst[31:26] == op_ldq)
            dec.rd_mem = 1'b1;
        end
        op_br, op_bsr:
        begin
          dec.opa_sel = opa_npc;
          dec.opb_sel = opb_br_disp;
          dec.alu_func = alu_addq;
          dest_sel = dest_rega; // return address
          dec.uncond_branch = 1'b1;
        end
        default:
          // 0x38..0x3f are integer conditional branches
          if (inst[31:29] == 3'b111)
          begin
            dec.opa_sel = opa_npc;
            dec.opb_sel = opb_br_disp;
            dec.alu_func = alu_addq;
            dec.cond_branch = 1'b1;
          end
          else
            dec.illegal = 1'b1; // fp, misc and unknown groups
      endcase
    end
    dec.valid = inst_valid & ~dec.illegal & ~dec.halt;
    if (!dec.valid)
      dest_sel = dest_none;
  end

  always_comb
  begin
    case (dest_sel)
      dest_rega: dest_arch = inst[25:21];
      dest_regc: dest_arch = inst[4:0];
      default:   dest_arch = zero_reg;
    endcase
  end

endmodule

/* hw/map_table.sv */
/*
  speculative architectural to physical map
  two combinational read ports and one write port
  restore replaces the whole table and wins over a write
  the caller keeps zero_reg out of rename_en
*/
`timescale 1ns/1ns

module map_table
  import id_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  arch_idx_t                 src_a,
  input  arch_idx_t                 src_b,
  input  logic                      rename_en,
  input  arch_idx_t                 dest_arch,
  input  phys_idx_t                 dest_phys,
  input  logic                      restore,
  input  phys_idx_t [arch_regs-1:0] restore_map,
  output phys_idx_t                 src_a_phys,
  output phys_idx_t                 src_b_phys
);

  phys_idx_t [arch_regs-1:0] spec_map;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  // no write bypass here
  // an instruction reads the mapping from before its own rename
  assign src_a_phys = spec_map[src_a];
  assign src_b_phys = spec_map[src_b];

  //////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      spec_map <= '0; // everything maps to p0, which reads ready
    else if (restore)
      spec_map <= restore_map; // committed state with same-cycle commit
    else if (rename_en)
      spec_map[dest_arch] <= dest_phys;
  end

endmodule

/* hw/ready_list.sv */
/*
  ready bit per physical register
  a nonzero cdb_tag sets its bit at the next edge and bypasses to the reads
  clear_set and clear_phys win over a set in the same cycle
  p0 always reads ready
*/
`timescale 1ns/1ns

module ready_list
  import id_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  phys_idx_t            cdb_tag,
  input  logic [phys_regs-1:0] clear_set,
  input  phys_idx_t            clear_phys,
  input  phys_idx_t            look_a,
  input  phys_idx_t            look_b,
  output logic                 ready_a,
  output logic                 ready_b
);

  logic [phys_regs-1:0] ready;
  logic [phys_regs-1:0] set_vec;
  logic [phys_regs-1:0] clr_vec;

  assign set_vec = (cdb_tag != '0) ? (phys_regs'(1) << cdb_tag) : '0;
  assign clr_vec = clear_set | ((clear_phys != '0) ? (phys_regs'(1) << clear_phys) : '0);

  assign ready_a = (look_a == '0) || ready[look_a] || (cdb_tag != '0 && look_a == cdb_tag);
  assign ready_b = (look_b == '0) || ready[look_b] || (cdb_tag != '0 && look_b == cdb_tag);

  always_ff @(posedge clock)
  begin
    if (reset)
      ready <= '0;
    else
      ready <= (ready | set_vec) & ~clr_vec;
  end

endmodule

/* hw/retire_map.sv */
/*
  committed map and committed free set
  a valid commit lands at the next edge
  committed_map and committed_free already include the commit of this cycle
  so a mispredict in the same cycle restores the right state
  freed_phys is 0 when no commit happens or the old mapping was p0
*/
`timescale 1ns/1ns

module retire_map
  import id_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  commit_t                   commit,
  output phys_idx_t [arch_regs-1:0] committed_map,
  output logic [phys_regs-1:0]      committed_free,
  output phys_idx_t                 freed_phys
);

  phys_idx_t [arch_regs-1:0] ret_map;
  logic [phys_regs-1:0]      ret_free;
  phys_idx_t [arch_regs-1:0] map_next;
  logic [phys_regs-1:0]      free_next;

  always_comb
  begin
    map_next = ret_map;
    free_next = ret_free;
    freed_phys = '0;
    if (commit.valid)
    begin
      freed_phys = ret_map[commit.arch]; // mapping being displaced
      map_next[commit.arch] = commit.phys;
      free_next[commit.phys] = 1'b0;
      if (freed_phys != '0)
        free_next[freed_phys] = 1'b1; // p0 never goes back
    end
  end

  // bypassed view
  assign committed_map  = map_next;
  assign committed_free = free_next;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      ret_map  <= '0;
      ret_free <= init_free;
    end
    else
    begin
      ret_map  <= map_next;
      ret_free <= free_next;
    end
  end

endmodule

/* rename_decode.f */
hw/id_pkg.sv
hw/inst_decoder.sv
hw/map_table.sv
hw/retire_map.sv
hw/free_list.sv
hw/ready_list.sv
hw/id_stage.sv
testbench/id_stage_sva.sv
testbench/id_stage_tb.sv

/* testbench/id_stage_sva.sv */
/*
  protocol rules of the rename stage, bound to every id_stage
  sampled on the rising edge and idle during reset
  fail_count holds the number of failed checks
*/
`timescale 1ns/1ns

module id_stage_sva
  import id_pkg::*;
(
  input logic      clock,
  input logic      reset,
  input logic      inst_valid,
  input logic      stall,
  input logic      rename_en,
  input phys_idx_t dest_phys
);

  int fail_count = 0;

  // back-pressure only comes from a real instruction
  stall_needs_valid: assert property (@(posedge clock) disable iff (reset)
    stall |-> inst_valid)
  else
  begin
    fail_count++;
    $error("stall high while inst_valid is low");
  end

  stall_no_dest: assert property (@(posedge clock) disable iff (reset)
    stall |-> (dest_phys == '0))
  else
  begin
    fail_count++;
    $error("dest_phys nonzero during stall");
  end

  rename_has_dest: assert property (@(posedge clock) disable iff (reset)
    rename_en |-> (dest_phys != '0)) // p0 is never handed out
  else
  begin
    fail_count++;
    $error("rename_en with dest_phys of 0");
  end

endmodule

bind id_stage id_stage_sva sva0 (.*);

/* testbench/id_stage_tb.sv */
/*
  testbench for the decode and rename stage
  inputs change on the rising edge, outputs are sampled on the falling edge
  a reference model of map, free and ready bits tracks every cycle it drives
  commits always follow real allocations, zero_reg is never committed
*/
`timescale 1ns/1ns

module id_stage_tb;
  import id_pkg::*;

  logic        clock;
  logic        reset;
  logic [31:0] inst;
  logic        inst_valid;
  commit_t     commit;
  logic        mispredict;
  phys_idx_t   cdb_tag;
  decode_t     dec;
  phys_idx_t   src_a_phys;
  phys_idx_t   src_b_phys;
  logic        src_a_ready;
  logic        src_b_ready;
  arch_idx_t   dest_arch;
  phys_idx_t   dest_phys;
  logic        stall;

  int          checks = 0;
  int          errors = 0;
  int          sva_errors;
  logic        timed_out = 1'b0;
  logic [31:0] lfsr = 32'h271f_3fdb;

  // reference model
  phys_idx_t            model_map [arch_regs];
  phys_idx_t            ret_map_m [arch_regs];
  logic [phys_regs-1:0] model_free;
  logic [phys_regs-1:0] ret_free_m;
  logic [phys_regs-1:0] model_ready;

  id_stage dut0 (.*);

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic arch_idx_t rand_arch();
    logic [31:0] r;
    r = rand_bits(5);
    return arch_idx_t'(r % 31); // never zero_reg
  endfunction

  function automatic phys_idx_t highest_free();
    phys_idx_t p;
    p = '0;
    for (int i = phys_regs - 1; i > 0; i--)
    begin
      if (model_free[i] && p == '0)
        p = phys_idx_t'(i);
    end
    return p;
  endfunction

  function automatic logic ready_rule(input arch_idx_t arch, input phys_idx_t p,
                                      input phys_idx_t tag);
    return (arch == zero_reg) || (p == '0) || model_ready[p] || (tag != '0 && p == tag);
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b1;
    inst_valid <= 1'b0;
    commit <= '0;
    mispredict <= 1'b0;
    cdb_tag <= '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < arch_regs; i++)
    begin
      model_map[i] = '0;
      ret_map_m[i] = '0;
    end
    model_free = init_free;
    ret_free_m = init_free;
    model_ready = '0;
  endtask

  // addq rc = ra + rb, checked against the model, then the model takes the edge
  task automatic rename_op(input arch_idx_t ra, input arch_idx_t rb, input arch_idx_t rc,
                           input phys_idx_t tag, output phys_idx_t got);
    phys_idx_t exp_dest;
    logic      exp_stall;
    @(posedge clock);
    inst <= {op_inta, ra, rb, 3'b000, 1'b0, fn_addq, rc};
    inst_valid <= 1'b1;
    commit <= '0;
    mispredict <= 1'b0;
    cdb_tag <= tag;
    @(negedge clock);
    exp_dest = '0;
    exp_stall = 1'b0;
    if (rc != zero_reg)
    begin
      exp_dest = highest_free();
      exp_stall = (exp_dest == '0);
    end
    compare("src_a_phys", src_a_phys, model_map[ra]);
    compare("src_b_phys", src_b_phys, model_map[rb]);
    compare("src_a_ready", src_a_ready, ready_rule(ra, model_map[ra], tag));
    compare("src_b_ready", src_b_ready, ready_rule(rb, model_map[rb], tag));
    compare("dest_phys", dest_phys, exp_dest);
    compare("stall", stall, exp_stall);
    got = dest_phys;
    if (tag != '0)
      model_ready[tag] = 1'b1;
    if (exp_dest != '0)
    begin
      model_free[exp_dest] = 1'b0;
      model_map[rc] = exp_dest;
      model_ready[exp_dest] = 1'b0; // clear beats the tag
    end
  endtask

  task automatic commit_reg(input arch_idx_t arch, input phys_idx_t phys, input logic hold);
    phys_idx_t old;
    @(posedge clock);
    commit <= '{valid: 1'b1, arch: arch, phys: phys};
    mispredict <= 1'b0;
    cdb_tag <= '0;
    if (!hold)
      inst_valid <= 1'b0;
    @(negedge clock);
    if (hold)
      compare("stall", stall, 1'b1);
    old = ret_map_m[arch];
    ret_map_m[arch] = phys;
    ret_free_m[phys] = 1'b0;
    if (old != '0)
    begin
      ret_free_m[old] = 1'b1;
      model_free[old] = 1'b1;
      model_ready[old] = 1'b0;
    end
  endtask

  // mispredict with a commit and a renaming instruction in the same cycle
  task automatic recover(input arch_idx_t arch, input phys_idx_t phys);
    phys_idx_t old;
    @(posedge clock);
    inst <= {op_inta, 5'd0, 5'd0, 3'b000, 1'b0, fn_addq, 5'd7};
    inst_valid <= 1'b1;
    commit <= '{valid: 1'b1, arch: arch, phys: phys};
    mispredict <= 1'b1;
    cdb_tag <= '0;
    @(negedge clock);
    compare("dest_phys", dest_phys, '0); // recovery wins over allocation
    old = ret_map_m[arch];
    ret_map_m[arch] = phys;
    ret_free_m[phys] = 1'b0;
    if (old != '0)
      ret_free_m[old] = 1'b1;
    model_map = ret_map_m;
    model_free = ret_free_m;
    model_ready = model_ready & ~ret_free_m;
  endtask

  task automatic decode_one(input logic [31:0] word);
    @(posedge clock);
    inst <= word;
    inst_valid <= 1'b1;
    @(negedge clock);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic decode_tests();
    decode_one({op_inta, 5'd1, 5'd2, 3'b000, 1'b0, fn_addq, 5'd5});
    compare("dec.alu_func", dec.alu_func, alu_addq);
    compare("dec.opb_sel", dec.opb_sel, opb_regb);
    compare("dest_arch", dest_arch, 5);
    compare("dec.valid", dec.valid, 1'b1);
    decode_one({6'h16, 26'h0}); // fp operate group
    compare("dec.illegal", dec.illegal, 1'b1);
    compare("dec.valid", dec.valid, 1'b0);
    decode_one({op_stq, 5'd3, 5'd4, 16'h0010});
    compare("dec.wr_mem", dec.wr_mem, 1'b1);
    compare("dest_arch", dest_arch, zero_reg);
    decode_one({op_ldq, 5'd6, 5'd4, 16'h0008});
    compare("dec.rd_mem", dec.rd_mem, 1'b1);
    compare("dest_arch", dest_arch, 6);
    decode_one({op_br, 5'd26, 21'h4});
    compare("dec.uncond_branch", dec.uncond_branch, 1'b1);
    compare("dec.opa_sel", dec.opa_sel, opa_npc);
    decode_one({6'h39, 5'd2, 21'h10}); // beq
    compare("dec.cond_branch", dec.cond_branch, 1'b1);
    compare("dest_arch", dest_arch, zero_reg);
    decode_one({op_pal, pal_halt});
    compare("dec.halt", dec.halt, 1'b1);
    compare("dec.valid", dec.valid, 1'b0);
  endtask

  task automatic rename_tests();
    phys_idx_t got;
    phys_idx_t p;
    arch_idx_t r;
    for (int i = 0; i < 6; i++)
    begin
      rename_op(rand_arch(), rand_arch(), rand_arch(), '0, got);
      compare("dest_phys", got, 63 - i);
    end
    rename_op(rand_arch(), rand_arch(), zero_reg, 6'd57, got); // p57 ready before use
    compare("dest_phys", got, 0);
    r = rand_arch();
    rename_op(rand_arch(), rand_arch(), r, '0, p);
    compare("dest_phys", p, 57); // zero_reg consumed nothing
    rename_op(r, r, zero_reg, '0, got);
    compare("src_a_phys", src_a_phys, p);
    compare("src_b_phys", src_b_phys, p);
    compare("src_a_ready", src_a_ready, 1'b0);
    rename_op(r, zero_reg, zero_reg, p, got); // tag on the bus this cycle
    compare("src_a_ready", src_a_ready, 1'b1);
    compare("src_b_ready", src_b_ready, 1'b1);
    rename_op(r, r, zero_reg, '0, got);
    compare("src_a_ready", src_a_ready, 1'b1);
  endtask

  task automatic exhaust_tests();
    phys_idx_t got;
    arch_idx_t ra;
    arch_idx_t rb;
    arch_idx_t rc;
    int        n;
    n = 0;
    while (stall !== 1'b1)
    begin
      if (n > phys_regs + 4)
      begin
        errors++;
        timed_out = 1'b1;
        $display("timed out waiting for stall after renames without commits");
        return;
      end
      ra = rand_arch();
      rb = rand_arch();
      rc = rand_arch();
      rename_op(ra, rb, rc, '0, got);
      n++;
    end
    compare("renames before stall", n - 1, 63);
    compare("dest_phys", dest_phys, 0);
    commit_reg(5'd1, 6'd63, 1'b1);
    commit_reg(5'd1, 6'd62, 1'b1); // displaces p63
    rename_op(ra, rb, rc, '0, got);
    compare("dest_phys", got, 63);
  endtask

  task automatic recovery_tests();
    phys_idx_t got;
    phys_idx_t exp;
    rename_op(5'd0, 5'd0, 5'd1, '0, got);
    rename_op(5'd0, 5'd0, 5'd2, '0, got);
    rename_op(5'd0, 5'd0, 5'd3, '0, got);
    commit_reg(5'd1, 6'd63, 1'b0);
    commit_reg(5'd2, 6'd62, 1'b0);
    rename_op(5'd0, 5'd0, 5'd1, '0, got); // wrong path from here
    rename_op(5'd0, 5'd0, 5'd4, '0, got);
    recover(5'd3, 6'd61); // r3 commits in the mispredict cycle
    for (int a = 0; a < arch_regs - 1; a++)
    begin
      rename_op(arch_idx_t'(a), arch_idx_t'(a), zero_reg, '0, got);
      exp = (a == 1) ? 6'd63 : (a == 2) ? 6'd62 : (a == 3) ? 6'd61 : 6'd0;
      compare("src_a_phys", src_a_phys, exp);
      compare("src_b_phys", src_b_phys, exp);
    end
    rename_op(5'd5, 5'd5, 5'd6, '0, got);
    compare("dest_phys", got, 60);
  endtask

  initial
  begin
    reset = 1'b1;
    inst = '0;
    inst_valid = 1'b0;
    commit = '0;
    mispredict = 1'b0;
    cdb_tag = '0;
    apply_reset();
    decode_tests();
    apply_reset();
    rename_tests();
    apply_reset();
    exhaust_tests();
    if (!timed_out)
    begin
      apply_reset();
      recovery_tests();
    end
    @(posedge clock);
    inst_valid <= 1'b0;
    @(negedge clock);
    sva_errors = dut0.sva0.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_errors);
    if (errors == 0 && sva_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
